/* rp_pkg.sv */
`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Analog data path widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned chan_num     = 2;                  // ADC and DAC channels
  localparam int unsigned adc_raw_w    = 16;                 // Raw converter word
  localparam int unsigned smp_w        = 14;                 // Sample width
  localparam int unsigned adc_lsb_drop = adc_raw_w - smp_w;  // Unused low ADC bits
  localparam int unsigned sum_w        = smp_w + 1;          // Mixer sum, one guard bit

  // Two's complement sample
  typedef logic signed [smp_w-1:0] smp_t;

  // Per-channel bundles
  typedef smp_t [chan_num-1:0] smp_arr_t;
  typedef logic [chan_num-1:0][adc_raw_w-1:0] adc_raw_arr_t;
  typedef logic [chan_num-1:0][smp_w-1:0] dac_code_arr_t;  // Neg-slope offset code

  // Saturation limits
  localparam smp_t smp_max = {1'b0, {(smp_w-1){1'b1}}};  // +8191
  localparam smp_t smp_min = {1'b1, {(smp_w-1){1'b0}}};  // -8192

  // DAC code for sample zero, sign kept and rest inverted
  localparam logic [smp_w-1:0] dac_code_zero = {1'b0, {(smp_w-1){1'b1}}};

  //////////////////////////////////////////////////////////////////////
  // Expansion connector and daisy chain
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned exp_w        = 8;   // Pins per connector side
  localparam int unsigned trig_in_pin  = 0;   // p side, external trigger in
  localparam int unsigned trig_out_pin = 0;   // n side, trigger out
  localparam int unsigned daisy_w      = 16;  // Received daisy word

  // Pin drive of one connector side
  typedef struct packed {
    logic [exp_w-1:0] dat;  // Output data
    logic [exp_w-1:0] oe;   // 1 = pin is output
  } exp_drv_t;

  // Daisy mode bits, bit 0 is sync
  typedef struct packed {
    logic sel_asg;   // Generator trigger out, else scope
    logic trig_pin;  // Trigger takes pin n0
    logic sync;      // Daisy sync mode
  } daisy_mode_t;

  //////////////////////////////////////////////////////////////////////
  // PLL lock diagnostics
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned lock_cnt_w = 32;  // Unlocked cycle counter

endpackage : rp_pkg

`default_nettype wire

/* lock_monitor.sv */
`default_nettype none

module lock_monitor
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic                  pll_locked_i,   // From clock generator
  output logic                  path_rst_n_o,   // Data path clear, active low
  output logic [lock_cnt_w-1:0] lock_cnt_o      // Cycles spent without lock
);

  //////////////////////////////////////////////////////////////////////
  // Data path reset
  //////////////////////////////////////////////////////////////////////

  // Released only once the PLL reports lock
  // One cycle behind pll_locked_i
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      path_rst_n_o <= 1'b0;  // Hold path in reset
    end else begin
      path_rst_n_o <= pll_locked_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lock loss counter
  //////////////////////////////////////////////////////////////////////

  // Diagnostic only, free running while unlocked
  // Wraps at all ones, no saturation
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_cnt_o <= '0;
    end else if (!pll_locked_i) begin
      lock_cnt_o <= lock_cnt_o + 1'b1;  // One per unlocked cycle
    end
  end

  // Counter keeps running through path reset
  // so that a long drop reads back as its real length

endmodule : lock_monitor

`default_nettype wire

/* adc_frontend.sv */
`default_nettype none

module adc_frontend
  import rp_pkg::*;
(
  input  logic         adc_clk,
  input  logic         arst_n_i,
  input  logic         path_rst_n_i,    // Sync clear from lock monitor
  input  adc_raw_arr_t adc_dat_i,       // Raw converter words
  input  logic         digital_loop_i,  // 1 = take DAC samples
  input  smp_arr_t     dac_smp_i,       // Saturated DAC samples
  output smp_arr_t     adc_dat_o        // Two's complement samples
);

  logic [chan_num-1:0][smp_w-1:0] adc_trim;  // Upper 14 bits of each word
  smp_arr_t                       adc_cnv;   // After sign conversion
  smp_arr_t                       adc_nxt;   // Loopback selected

  //////////////////////////////////////////////////////////////////////
  // Trim and convert
  //////////////////////////////////////////////////////////////////////

  // Converter gives negative slope offset code
  // MSB is already the sign, remaining bits run the wrong way
  always_comb begin
    for (int c = 0; c < chan_num; c++) begin
      adc_trim[c] = adc_dat_i[c][adc_raw_w-1:adc_lsb_drop];      // Drop 2 LSBs
      adc_cnv[c]  = {adc_trim[c][smp_w-1], ~adc_trim[c][smp_w-2:0]};
    end
  end

  // Digital loopback replaces both channels at once
  assign adc_nxt = digital_loop_i ? dac_smp_i : adc_cnv;

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_dat_o <= '0;
    end else if (!path_rst_n_i) begin
      adc_dat_o <= '0;       // Zero while PLL unlocked
    end else begin
      adc_dat_o <= adc_nxt;  // New sample every cycle
    end
  end

endmodule : adc_frontend

`default_nettype wire

/* dac_mixer.sv */
`default_nettype none

module dac_mixer
  import rp_pkg::*;
(
  input  logic          adc_clk,
  input  logic          arst_n_i,
  input  logic          path_rst_n_i,  // Sync clear from lock monitor
  input  smp_arr_t      asg_dat_i,     // Generator samples
  input  smp_arr_t      pid_dat_i,     // PID samples
  output smp_arr_t      dac_smp_o,     // Saturated sum, same cycle
  output dac_code_arr_t dac_dat_o      // Registered converter code
);

  logic signed [sum_w-1:0] sum [chan_num];  // Sum with guard bit
  logic [chan_num-1:0]     ovf;             // Sum left 14 bit range
  smp_arr_t                sat;             // Clamped sum
  dac_code_arr_t           dac_code;        // Offset code before register

  //////////////////////////////////////////////////////////////////////
  // Sum and saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < chan_num; c++) begin
      // Both operands signed, sign extended to 15 bits
      sum[c] = asg_dat_i[c] + pid_dat_i[c];

      // Top two bits disagree on overflow
      ovf[c] = sum[c][sum_w-1] ^ sum[c][sum_w-2];

      if (ovf[c]) begin
        sat[c] = sum[c][sum_w-1] ? smp_min : smp_max;  // Clamp by true sign
      end else begin
        sat[c] = sum[c][smp_w-1:0];
      end
    end
  end

  // Loopback source for the ADC side
  assign dac_smp_o = sat;

  //////////////////////////////////////////////////////////////////////
  // Offset code and output register
  //////////////////////////////////////////////////////////////////////

  // Keep sign, flip the rest, same mapping as the ADC
  always_comb begin
    for (int c = 0; c < chan_num; c++) begin
      dac_code[c] = {sat[c][smp_w-1], ~sat[c][smp_w-2:0]};
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_dat_o <= {chan_num{dac_code_zero}};  // Mid scale
    end else if (!path_rst_n_i) begin
      dac_dat_o <= {chan_num{dac_code_zero}};  // Park output at zero
    end else begin
      dac_dat_o <= dac_code;
    end
  end

endmodule : dac_mixer

`default_nettype wire

/* exp_pin_mux.sv */
`default_nettype none

module exp_pin_mux
  import rp_pkg::*;
(
  input  daisy_mode_t        daisy_mode_i,  // From housekeeping
  input  logic [daisy_w-1:0] daisy_dat_i,   // Daisy received word
  input  logic               asg_trig_i,    // Generator trigger out
  input  logic               scope_trig_i,  // Scope trigger out
  input  logic [exp_w-1:0]   exp_p_in_i,    // p side pin levels
  input  exp_drv_t           hk_p_drv_i,    // Housekeeping p drive
  input  exp_drv_t           hk_n_drv_i,    // Housekeeping n drive
  output logic               trig_ext_o,    // External trigger
  output exp_drv_t           exp_p_drv_o,   // To p side buffers
  output exp_drv_t           exp_n_drv_o    // To n side buffers
);

  logic daisy_trig;  // Any daisy data bit set
  logic trig_blk;    // Block external trigger
  logic trig_sel;    // Outgoing trigger

  //////////////////////////////////////////////////////////////////////
  // External trigger
  //////////////////////////////////////////////////////////////////////

  // In sync mode the daisy word carries the trigger burst
  assign daisy_trig = |daisy_dat_i;
  assign trig_blk   = daisy_mode_i.sync & daisy_trig;

  // Pin p0 is the trigger input
  assign trig_ext_o = exp_p_in_i[trig_in_pin] & ~trig_blk;

  //////////////////////////////////////////////////////////////////////
  // Outgoing trigger and pin override
  //////////////////////////////////////////////////////////////////////

  // Generator or scope
  assign trig_sel = daisy_mode_i.sel_asg ? asg_trig_i : scope_trig_i;

  // No alternate function on the p side
  assign exp_p_drv_o = hk_p_drv_i;

  // n side follows housekeeping except pin n0 in trigger mode
  always_comb begin
    exp_n_drv_o = hk_n_drv_i;  // Default pass through
    if (daisy_mode_i.trig_pin) begin
      exp_n_drv_o.dat[trig_out_pin] = trig_sel;
      exp_n_drv_o.oe[trig_out_pin]  = 1'b1;  // Force output
    end
  end

  // Housekeeping direction bit for n0 is ignored
  // while the override is active

endmodule : exp_pin_mux

`default_nettype wire

/* rp_analog_top.sv */
`default_nettype none

module rp_analog_top
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic                  pll_locked_i,    // PLL lock status
  // ADC
  input  adc_raw_arr_t          adc_dat_i,       // Raw ADC words
  input  logic                  digital_loop_i,  // Loop DAC back to ADC
  // Generator and PID samples
  input  smp_arr_t              asg_dat_i,
  input  smp_arr_t              pid_dat_i,
  // Triggers
  input  logic                  asg_trig_i,
  input  logic                  scope_trig_i,
  // Daisy chain
  input  daisy_mode_t           daisy_mode_i,
  input  logic [daisy_w-1:0]    daisy_dat_i,
  // Expansion connector
  input  logic [exp_w-1:0]      exp_p_in_i,
  input  exp_drv_t              hk_p_drv_i,
  input  exp_drv_t              hk_n_drv_i,
  // Outputs
  output smp_arr_t              adc_dat_o,       // Converted ADC samples
  output dac_code_arr_t         dac_dat_o,       // DAC codes, both channels
  output logic                  trig_ext_o,      // External trigger
  output exp_drv_t              exp_p_drv_o,
  output exp_drv_t              exp_n_drv_o,
  output logic [lock_cnt_w-1:0] lock_cnt_o       // Unlocked cycle count
);

  logic     path_rst_n;  // Data path clear
  smp_arr_t dac_smp;     // Saturated sum for loopback

  //////////////////////////////////////////////////////////////////////
  // PLL lock monitor
  //////////////////////////////////////////////////////////////////////

  lock_monitor i_lock_monitor (
    .adc_clk      (adc_clk     ),
    .arst_n_i     (arst_n_i    ),
    .pll_locked_i (pll_locked_i),
    .path_rst_n_o (path_rst_n  ),
    .lock_cnt_o   (lock_cnt_o  )
  );

  //////////////////////////////////////////////////////////////////////
  // ADC front end
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk       ),
    .arst_n_i       (arst_n_i      ),
    .path_rst_n_i   (path_rst_n    ),
    .adc_dat_i      (adc_dat_i     ),
    .digital_loop_i (digital_loop_i),
    .dac_smp_i      (dac_smp       ),  // Same cycle sum
    .adc_dat_o      (adc_dat_o     )
  );

  //////////////////////////////////////////////////////////////////////
  // DAC mixer
  //////////////////////////////////////////////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk      (adc_clk   ),
    .arst_n_i     (arst_n_i  ),
    .path_rst_n_i (path_rst_n),
    .asg_dat_i    (asg_dat_i ),
    .pid_dat_i    (pid_dat_i ),
    .dac_smp_o    (dac_smp   ),
    .dac_dat_o    (dac_dat_o )
  );

  //////////////////////////////////////////////////////////////////////
  // Triggers and expansion pins
  //////////////////////////////////////////////////////////////////////

  exp_pin_mux i_exp_pin_mux (
    .daisy_mode_i (daisy_mode_i),
    .daisy_dat_i  (daisy_dat_i ),
    .asg_trig_i   (asg_trig_i  ),
    .scope_trig_i (scope_trig_i),
    .exp_p_in_i   (exp_p_in_i  ),
    .hk_p_drv_i   (hk_p_drv_i  ),
    .hk_n_drv_i   (hk_n_drv_i  ),
    .trig_ext_o   (trig_ext_o  ),  // Not gated by lock
    .exp_p_drv_o  (exp_p_drv_o ),
    .exp_n_drv_o  (exp_n_drv_o )
  );

endmodule : rp_analog_top

`default_nettype wire

/* rp_analog_assertions.sv */
`default_nettype none

module rp_analog_assertions
  import rp_pkg::*;
(
  input logic               adc_clk,
  input logic               arst_n_i,
  input logic               path_rst_n_i,  // Internal data path clear
  input dac_code_arr_t      dac_dat_i,
  input daisy_mode_t        daisy_mode_i,
  input logic [daisy_w-1:0] daisy_dat_i,
  input logic               trig_ext_i,
  input exp_drv_t           exp_n_drv_i
);

  int assert_fail_cnt = 0;  // Failure tally

  // DAC parked at mid scale one edge after a path clear
  dac_parked_a : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !$past(path_rst_n_i) |-> (dac_dat_i == {14'd8191, 14'd8191}))
  else begin
    $error("DAC code not at mid scale after data path clear");
    assert_fail_cnt++;
  end

  // Pin n0 always an output in trigger mode
  trig_pin_oe_a : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    daisy_mode_i.trig_pin |-> exp_n_drv_i.oe[trig_out_pin])
  else begin
    $error("Pin n0 not enabled as output in trigger mode");
    assert_fail_cnt++;
  end

  // Daisy burst blocks the external trigger
  trig_blocked_a : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (daisy_mode_i.sync && (daisy_dat_i != '0)) |-> !trig_ext_i)
  else begin
    $error("External trigger passed during daisy sync burst");
    assert_fail_cnt++;
  end

endmodule : rp_analog_assertions

bind rp_analog_top rp_analog_assertions i_rp_analog_assertions (
  .adc_clk      (adc_clk     ),
  .arst_n_i     (arst_n_i    ),
  .path_rst_n_i (path_rst_n  ),
  .dac_dat_i    (dac_dat_o   ),
  .daisy_mode_i (daisy_mode_i),
  .daisy_dat_i  (daisy_dat_i ),
  .trig_ext_i   (trig_ext_o  ),
  .exp_n_drv_i  (exp_n_drv_o )
);

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
  output logic adc_clk_o,  // 8 unit period
  output logic arst_n_o    // Low for the first 5 cycles
);

  initial begin
    adc_clk_o = 1'b0;
    forever #4 adc_clk_o = ~adc_clk_o;
  end

  // Release just after an edge, like the rest of the stimulus
  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge adc_clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

/* tb_rp_analog_top.sv */
`default_nettype none

module tb_rp_analog_top
  import rp_pkg::*;
();

  // Same names as the DUT ports
  logic                  adc_clk;
  logic                  arst_n_i;
  logic                  pll_locked_i;
  adc_raw_arr_t          adc_dat_i;
  logic                  digital_loop_i;
  smp_arr_t              asg_dat_i;
  smp_arr_t              pid_dat_i;
  logic                  asg_trig_i;
  logic                  scope_trig_i;
  daisy_mode_t           daisy_mode_i;
  logic [daisy_w-1:0]    daisy_dat_i;
  logic [exp_w-1:0]      exp_p_in_i;
  exp_drv_t              hk_p_drv_i;
  exp_drv_t              hk_n_drv_i;
  smp_arr_t              adc_dat_o;
  dac_code_arr_t         dac_dat_o;
  logic                  trig_ext_o;
  exp_drv_t              exp_p_drv_o;
  exp_drv_t              exp_n_drv_o;
  logic [lock_cnt_w-1:0] lock_cnt_o;

  integer seed         = 32'hb1d9_6d0d;
  int     err_cnt      = 0;  // Whole run
  int     test_err     = 0;  // Running test only
  int     test_cnt     = 0;
  int     bad_test_cnt = 0;

  tb_clk_gen i_tb_clk_gen (.adc_clk_o(adc_clk), .arst_n_o(arst_n_i));

  rp_analog_top i_rp_analog_top (.*);

  //////////////////////////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////////////////////////

  // Upper 14 bits, magnitude bits flipped
  function automatic logic [smp_w-1:0] adc_expect(logic [adc_raw_w-1:0] raw);
    return raw[adc_raw_w-1:2] ^ 14'h1fff;
  endfunction

  function automatic int clamp_sum(int a, int b);
    int s;
    s = a + b;
    if (s > 8191) begin
      s = 8191;            // Positive full scale
    end else if (s < -8192) begin
      s = -8192;
    end
    return s;
  endfunction

  function automatic logic [smp_w-1:0] dac_expect(int s);
    return 14'(s) ^ 14'h1fff;  // Sign kept
  endfunction

  // Uniform over the whole 14 bit range
  function automatic int rand_smp();
    return ($random(seed) & 32'h3fff) - 8192;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge adc_clk);
    #1;                    // Drive point after the edge
  endtask

  task automatic report_mismatch(string test, string what,
                                 logic [63:0] exp, logic [63:0] act);
    $display("ERROR %s %s: expected %0h, actual %0h", test, what, exp, act);
    test_err++;
    err_cnt++;
  endtask

  task automatic finish_test(string test);
    test_cnt++;
    if (test_err == 0) begin
      $display("%s: ok", test);
    end else begin
      bad_test_cnt++;
      $display("%s: %0d errors", test, test_err);
    end
  endtask

  task automatic release_reset();
    int n;
    test_err = 0;
    n = 0;
    while (arst_n_i !== 1'b1 && n < 20) begin
      step();
      n++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("Reset was never released");
      test_err++;
      err_cnt++;
    end
    if (adc_dat_o !== '0) report_mismatch("reset", "adc", 0, adc_dat_o);
    if (dac_dat_o !== {14'd8191, 14'd8191})
      report_mismatch("reset", "dac", {14'd8191, 14'd8191}, dac_dat_o);
    if (lock_cnt_o !== '0) report_mismatch("reset", "lock_cnt", 0, lock_cnt_o);
    finish_test("reset");
    step();                // Path clear lags by a cycle
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic convert_adc_words();
    adc_raw_arr_t raw;
    test_err = 0;
    digital_loop_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      raw = {16'($random(seed)), 16'($random(seed))};
      adc_dat_i = raw;
      step();
      if (adc_dat_o !== {adc_expect(raw[1]), adc_expect(raw[0])})
        report_mismatch("adc_conversion", "adc", {adc_expect(raw[1]), adc_expect(raw[0])},
                        adc_dat_o);
    end
    finish_test("adc_conversion");
  endtask

  // In range, exactly at both limits, past both limits
  task automatic mix_dac_samples();
    int a_v [10] = '{100, -3000, 4000, -4096, 8191, -8192, 8191, -8192, 5000, 0};
    int b_v [10] = '{200, 1500, 4191, -4096, 1, -1, 8191, -8192, -5000, -1};
    logic [2*smp_w-1:0] exp;
    test_err = 0;
    for (int i = 0; i < 10; i++) begin
      asg_dat_i = {14'(a_v[9-i]), 14'(a_v[i])};  // Channel 1 runs backwards
      pid_dat_i = {14'(b_v[9-i]), 14'(b_v[i])};
      step();
      exp = {dac_expect(clamp_sum(a_v[9-i], b_v[9-i])), dac_expect(clamp_sum(a_v[i], b_v[i]))};
      if (dac_dat_o !== exp) report_mismatch("dac_mixing", $sformatf("pair %0d", i), exp, dac_dat_o);
    end
    finish_test("dac_mixing");
  endtask

  task automatic loop_dac_to_adc();
    int a0, a1, b0, b1;
    logic [2*smp_w-1:0] exp;
    test_err = 0;
    digital_loop_i = 1'b1;
    for (int i = 0; i < 24; i++) begin
      a0 = rand_smp();
      a1 = rand_smp();
      b0 = rand_smp();
      b1 = rand_smp();
      asg_dat_i = {14'(a1), 14'(a0)};
      pid_dat_i = {14'(b1), 14'(b0)};
      adc_dat_i = {16'($random(seed)), 16'($random(seed))};  // Must be ignored
      step();
      exp = {14'(clamp_sum(a1, b1)), 14'(clamp_sum(a0, b0))};
      if (adc_dat_o !== exp) report_mismatch("loopback", "adc", exp, adc_dat_o);
    end
    digital_loop_i = 1'b0;
    finish_test("loopback");
  endtask

  // Combinational, checked in the same cycle
  task automatic route_triggers();
    logic     exp_trig;
    exp_drv_t exp_n;
    test_err = 0;
    for (int m = 0; m < 8; m++) begin
      for (int k = 0; k < 4; k++) begin
        daisy_mode_i = daisy_mode_t'(3'(m));
        daisy_dat_i  = 16'($random(seed));
        if ($random(seed) & 1) daisy_dat_i = '0;  // Idle word half the time
        asg_trig_i   = 1'($random(seed));
        scope_trig_i = 1'($random(seed));
        exp_p_in_i   = 8'($random(seed));
        hk_p_drv_i   = exp_drv_t'(16'($random(seed)));
        hk_n_drv_i   = exp_drv_t'(16'($random(seed)));
        #1;
        exp_trig = exp_p_in_i[trig_in_pin] && !(daisy_mode_i.sync && daisy_dat_i != '0);
        exp_n = hk_n_drv_i;
        if (daisy_mode_i.trig_pin) begin
          exp_n.oe[trig_out_pin]  = 1'b1;
          exp_n.dat[trig_out_pin] = daisy_mode_i.sel_asg ? asg_trig_i : scope_trig_i;
        end
        if (trig_ext_o !== exp_trig)
          report_mismatch("trigger", $sformatf("trig_ext mode %0d", m), exp_trig, trig_ext_o);
        if (exp_p_drv_o !== hk_p_drv_i)
          report_mismatch("trigger", $sformatf("p drive mode %0d", m), hk_p_drv_i, exp_p_drv_o);
        if (exp_n_drv_o !== exp_n)
          report_mismatch("trigger", $sformatf("n drive mode %0d", m), exp_n, exp_n_drv_o);
        step();
      end
    end
    finish_test("trigger");
  endtask

  task automatic drop_pll_lock();
    int k;
    int n;
    logic [lock_cnt_w-1:0] cnt_start;
    adc_raw_arr_t raw;
    test_err = 0;
    k = 3 + (($random(seed) & 32'h7fff_ffff) % 18);
    cnt_start = lock_cnt_o;
    pll_locked_i = 1'b0;
    for (int i = 1; i <= k; i++) begin
      adc_dat_i = {16'($random(seed)), 16'($random(seed))};
      asg_dat_i = {14'(rand_smp()), 14'(rand_smp())};
      step();
      // Clear reaches the data registers one edge late
      if (i >= 2 && adc_dat_o !== '0) report_mismatch("lock_loss", "adc", 0, adc_dat_o);
      if (i >= 2 && dac_dat_o !== {14'd8191, 14'd8191})
        report_mismatch("lock_loss", "dac", {14'd8191, 14'd8191}, dac_dat_o);
    end
    pll_locked_i = 1'b1;
    step();
    if (lock_cnt_o - cnt_start !== 32'(k))
      report_mismatch("lock_loss", "lock_cnt delta", k, lock_cnt_o - cnt_start);
    // Sign bit forced so a resumed sample is never zero
    n = 0;
    do begin
      raw = {16'($random(seed)) | 16'h8000, 16'($random(seed)) | 16'h8000};
      adc_dat_i = raw;
      step();
      n++;
    end while (adc_dat_o !== {adc_expect(raw[1]), adc_expect(raw[0])} && n < 4);
    if (adc_dat_o !== {adc_expect(raw[1]), adc_expect(raw[0])}) begin
      $display("Conversion did not resume after lock returned");
      test_err++;
      err_cnt++;
    end
    finish_test("lock_loss");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int asrt_cnt;
    pll_locked_i   = 1'b1;
    adc_dat_i      = '0;
    digital_loop_i = 1'b0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    asg_trig_i     = 1'b0;
    scope_trig_i   = 1'b0;
    daisy_mode_i   = '0;
    daisy_dat_i    = '0;
    exp_p_in_i     = '0;
    hk_p_drv_i     = '0;
    hk_n_drv_i     = '0;
    release_reset();
    convert_adc_words();
    mix_dac_samples();
    loop_dac_to_adc();
    route_triggers();
    drop_pll_lock();
    asrt_cnt = i_rp_analog_top.i_rp_analog_assertions.assert_fail_cnt;
    $display("tests %0d, failed tests %0d, errors %0d, assertion failures %0d",
             test_cnt, bad_test_cnt, err_cnt, asrt_cnt);
    if (err_cnt == 0 && asrt_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_rp_analog_top

`default_nettype wire

/* sim.f */
rp_pkg.sv
lock_monitor.sv
adc_frontend.sv
dac_mixer.sv
exp_pin_mux.sv
rp_analog_top.sv
rp_analog_assertions.sv
tb_clk_gen.sv
tb_rp_analog_top.sv

/* Bender.yml */
package:
  name: rp_analog

sources:
  - files:
      - rp_pkg.sv
      - lock_monitor.sv
      - adc_frontend.sv
      - dac_mixer.sv
      - exp_pin_mux.sv
      - rp_analog_top.sv
  - target: test
    files:
      - rp_analog_assertions.sv
      - tb_clk_gen.sv
      - tb_rp_analog_top.sv
